// File: hw/fetch_types_pkg.sv
// Fetch data types: widths and vector types for addresses, lines and instructions
`default_nettype none

package fetch_types_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int unsigned ADDR_W      = 64;
    localparam int unsigned LINE_W      = 64;
    localparam int unsigned INSTR_W     = 32;

    // Bytes per memory line and per instruction
    localparam int unsigned LINE_BYTES  = LINE_W / 8;
    localparam int unsigned INSTR_BYTES = INSTR_W / 8;

    // Address bits below the line boundary
    localparam int unsigned LINE_OFF_W  = $clog2(LINE_BYTES);

    // --------------------------------------------------
    // Vector types
    // --------------------------------------------------
    // Byte address
    typedef logic [ADDR_W-1:0]  addr_t;
    // One memory line, two instructions wide
    typedef logic [LINE_W-1:0]  line_t;
    // One uncompressed instruction
    typedef logic [INSTR_W-1:0] instr_t;

endpackage

`default_nettype wire

// File: hw/fetch_ctrl_pkg.sv
// Fetch control definitions: fetch FSM states and flow control constants
`default_nettype none

package fetch_ctrl_pkg;

    // Fetch unit FSM
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        FETCH     = 2'd1,
        WAIT_ROOM = 2'd2
    } fetch_state_e;

    // Free buffer entries needed before a new request (one slot is in flight)
    localparam int unsigned ROOM_MIN_FREE = 2;

    // PC bit that selects the upper instruction of a line
    localparam int unsigned HALF_BIT = 2;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
// Fetch unit that walks the fetch PC and issues line requests while the buffer has room
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  fetch_enable_i,
    input  addr_t boot_addr_i,
    input  logic  redirect_i,
    input  addr_t redirect_addr_i,
    input  logic  room_i,
    input  logic  gnt_i,
    output logic  req_o,
    output addr_t req_addr_o,
    output addr_t resp_addr_o,
    output logic  busy_o
);

    fetch_state_e state_q, state_d;
    addr_t        pc_q;
    addr_t        pc_line;
    addr_t        resp_addr_q;
    logic         booted_q;

    // Line aligned request address while the offset inside the line stays in pc_q
    assign pc_line    = {pc_q[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
    assign req_addr_o = pc_line;

    assign req_o  = (state_q == FETCH) && room_i;
    assign busy_o = (state_q != IDLE);

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (fetch_enable_i) begin
                    state_d = FETCH;
                end
            end
            FETCH: begin
                if (!fetch_enable_i) begin
                    state_d = IDLE;
                end else if (!room_i) begin
                    state_d = WAIT_ROOM;
                end
            end
            WAIT_ROOM: begin
                if (!fetch_enable_i) begin
                    state_d = IDLE;
                end else if (room_i) begin
                    state_d = FETCH;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // --------------------------------------------------
    // PC and state registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            pc_q     <= '0;
            booted_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (redirect_i) begin
                pc_q     <= redirect_addr_i;
                booted_q <= 1'b1;
            end else if (state_q == IDLE && fetch_enable_i && !booted_q) begin
                // First start takes the boot address
                pc_q     <= boot_addr_i;
                booted_q <= 1'b1;
            end else if (req_o && gnt_i) begin
                pc_q <= pc_line + addr_t'(LINE_BYTES);
            end
        end
    end

    // Address of the granted line is kept for the response one cycle later
    always_ff @(posedge clk_i) begin
        if (req_o && gnt_i) begin
            resp_addr_q <= pc_q;
        end
    end

    assign resp_addr_o = resp_addr_q;

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    a_req_needs_room : assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_o |-> room_i)
        else $error("fetch_unit: request while buffer has no room");

endmodule

`default_nettype wire

// File: hw/instr_mem.sv
// Instruction memory model with a line array, a preload write port and one-cycle reads
`timescale 1ns/1ps
`default_nettype none

module instr_mem
    import fetch_types_pkg::*;
#(
    parameter int unsigned MEM_LINES = 64
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         req_i,
    input  addr_t                        addr_i,
    output logic                         gnt_o,
    output logic                         rvalid_o,
    output line_t                        rdata_o,
    input  logic                         we_i,
    input  logic [$clog2(MEM_LINES)-1:0] waddr_i,
    input  line_t                        wdata_i
);

    localparam int unsigned IDX_W = $clog2(MEM_LINES);

    line_t             mem_q [MEM_LINES];
    logic  [IDX_W-1:0] ridx;
    logic              rvalid_q;
    line_t             rdata_q;

    // Line index wraps modulo the memory size
    assign ridx = addr_i[LINE_OFF_W +: IDX_W];

    // Every request is accepted right away
    assign gnt_o = req_i;

    // --------------------------------------------------
    // Preload port
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // --------------------------------------------------
    // Read response
    // --------------------------------------------------
    // Reads sample the array before a same-cycle write lands
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= req_i;
            rdata_q  <= req_i ? mem_q[ridx] : '0;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: hw/line_buffer.sv
// Line buffer: FIFO of fetched lines and their addresses with flush and room level
`timescale 1ns/1ps
`default_nettype none

module line_buffer
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
#(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  flush_i,
    input  logic  wr_i,
    input  line_t wr_line_i,
    input  addr_t wr_addr_i,
    input  logic  pop_i,
    output logic  room_o,
    output logic  valid_o,
    output line_t line_o,
    output addr_t addr_o
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    line_t line_q [BUF_DEPTH];
    addr_t addr_q [BUF_DEPTH];
    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    cnt_t  count_q;
    cnt_t  free_cnt;
    logic  drop_q;
    logic  wr_en;
    logic  pop_en;

    // A response in the cycle after a flush belongs to the old path
    assign wr_en  = wr_i && !flush_i && !drop_q;
    assign pop_en = pop_i && !flush_i;

    assign free_cnt = cnt_t'(BUF_DEPTH) - count_q;
    assign room_o   = (free_cnt >= cnt_t'(ROOM_MIN_FREE));
    assign valid_o  = (count_q != '0);
    assign line_o   = line_q[rd_ptr_q];
    assign addr_o   = addr_q[rd_ptr_q];

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            line_q[wr_ptr_q] <= wr_line_i;
            addr_q[wr_ptr_q] <= wr_addr_i;
        end
    end

    // --------------------------------------------------
    // Pointers and count
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            drop_q   <= 1'b0;
        end else begin
            drop_q <= flush_i;
            if (flush_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                // Pointers wrap on their own, the depth is a power of two
                if (wr_en) begin
                    wr_ptr_q <= wr_ptr_q + ptr_t'(1);
                end
                if (pop_en) begin
                    rd_ptr_q <= rd_ptr_q + ptr_t'(1);
                end
                if (wr_en && !pop_en) begin
                    count_q <= count_q + cnt_t'(1);
                end else if (pop_en && !wr_en) begin
                    count_q <= count_q - cnt_t'(1);
                end
            end
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    a_no_write_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_en |-> count_q != cnt_t'(BUF_DEPTH))
        else $error("line_buffer: write while full");

    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_en |-> valid_o)
        else $error("line_buffer: pop while empty");

endmodule

`default_nettype wire

// File: hw/instr_realign.sv
// Instruction realigner: splits buffered lines into 32-bit instructions, one per cycle
`timescale 1ns/1ps
`default_nettype none

module instr_realign
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   flush_i,
    input  logic   stall_i,
    input  logic   valid_i,
    input  line_t  line_i,
    input  addr_t  addr_i,
    output logic   pop_o,
    output logic   instr_valid_o,
    output instr_t instr_o,
    output addr_t  pc_o
);

    logic   mid_q;
    logic   cur_half;
    logic   issue;
    logic   out_valid_q;
    instr_t instr_q;
    addr_t  pc_q;
    addr_t  line_base;

    assign line_base = {addr_i[ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    // Upper half is next once the lower one went out, or when the
    // line was entered through a PC that points at its upper half
    assign cur_half = mid_q || addr_i[HALF_BIT];

    assign issue = valid_i && !stall_i && !flush_i;

    // Line is done after its upper half
    assign pop_o = issue && cur_half;

    // --------------------------------------------------
    // Half tracking
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mid_q <= 1'b0;
        end else if (flush_i) begin
            mid_q <= 1'b0;
        end else if (issue) begin
            mid_q <= !cur_half;
        end
    end

    // --------------------------------------------------
    // Output stage
    // --------------------------------------------------
    // Held while stalled, the shown instruction is taken when stall is low
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (!stall_i) begin
            out_valid_q <= issue;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            instr_q <= cur_half ? line_i[LINE_W-1:INSTR_W] : line_i[INSTR_W-1:0];
            pc_q    <= line_base + (cur_half ? addr_t'(INSTR_BYTES) : '0);
        end
    end

    assign instr_valid_o = out_valid_q && !stall_i && !flush_i;
    assign instr_o       = instr_q;
    assign pc_o          = pc_q;

endmodule

`default_nettype wire

// File: hw/fetch_subsys.sv
// Fetch subsystem top: fetch unit, instruction memory, line buffer and realigner
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys
    import fetch_types_pkg::*;
#(
    parameter int unsigned BUF_DEPTH = 4,
    parameter int unsigned MEM_LINES = 64
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         fetch_enable_i,
    input  addr_t                        boot_addr_i,
    input  logic                         redirect_i,
    input  addr_t                        redirect_addr_i,
    input  logic                         stall_i,
    input  logic                         mem_we_i,
    input  logic [$clog2(MEM_LINES)-1:0] mem_waddr_i,
    input  line_t                        mem_wdata_i,
    output logic                         instr_valid_o,
    output instr_t                       instr_o,
    output addr_t                        instr_pc_o,
    output logic                         fetch_busy_o
);

    // Memory request side
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_gnt;
    logic  mem_rvalid;
    line_t mem_rdata;
    addr_t resp_addr;

    // Buffer to realigner
    logic  buf_room;
    logic  buf_valid;
    line_t buf_line;
    addr_t buf_addr;
    logic  buf_pop;

    fetch_unit i_fetch_unit (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .fetch_enable_i  ( fetch_enable_i  ),
        .boot_addr_i     ( boot_addr_i     ),
        .redirect_i      ( redirect_i      ),
        .redirect_addr_i ( redirect_addr_i ),
        .room_i          ( buf_room        ),
        .gnt_i           ( mem_gnt         ),
        .req_o           ( mem_req         ),
        .req_addr_o      ( mem_addr        ),
        .resp_addr_o     ( resp_addr       ),
        .busy_o          ( fetch_busy_o    )
    );

    instr_mem #(
        .MEM_LINES ( MEM_LINES )
    ) i_instr_mem (
        .clk_i    ( clk_i       ),
        .rst_ni   ( rst_ni      ),
        .req_i    ( mem_req     ),
        .addr_i   ( mem_addr    ),
        .gnt_o    ( mem_gnt     ),
        .rvalid_o ( mem_rvalid  ),
        .rdata_o  ( mem_rdata   ),
        .we_i     ( mem_we_i    ),
        .waddr_i  ( mem_waddr_i ),
        .wdata_i  ( mem_wdata_i )
    );

    line_buffer #(
        .BUF_DEPTH ( BUF_DEPTH )
    ) i_line_buffer (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .flush_i   ( redirect_i ),
        .wr_i      ( mem_rvalid ),
        .wr_line_i ( mem_rdata  ),
        .wr_addr_i ( resp_addr  ),
        .pop_i     ( buf_pop    ),
        .room_o    ( buf_room   ),
        .valid_o   ( buf_valid  ),
        .line_o    ( buf_line   ),
        .addr_o    ( buf_addr   )
    );

    instr_realign i_instr_realign (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( redirect_i    ),
        .stall_i       ( stall_i       ),
        .valid_i       ( buf_valid     ),
        .line_i        ( buf_line      ),
        .addr_i        ( buf_addr      ),
        .pop_o         ( buf_pop       ),
        .instr_valid_o ( instr_valid_o ),
        .instr_o       ( instr_o       ),
        .pc_o          ( instr_pc_o    )
    );

endmodule

`default_nettype wire

// File: include/tb_fetch_tasks.svh
// Fetch testbench helpers: memory preload, reference instruction stream and result reporting
`ifndef TB_FETCH_TASKS_SVH
`define TB_FETCH_TASKS_SVH

// --------------------------------------------------
// Memory preload
// --------------------------------------------------
// Random lines through the write port, a copy stays in mem_copy
task automatic preload_mem();
    line_t data;
    for (int unsigned i = 0; i < MEM_LINES; i++) begin
        data = {$urandom, $urandom};
        @(posedge clk_i);
        #DRIVE_DELAY;
        mem_we_i    = 1'b1;
        mem_waddr_i = IDX_W'(i);
        mem_wdata_i = data;
        mem_copy[i] = data;
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    mem_we_i = 1'b0;
endtask

// --------------------------------------------------
// Reference model
// --------------------------------------------------
// Line index is PC / 8 modulo the memory size, PC bit 2 picks the half
function automatic instr_t ref_instr(input addr_t pc);
    int unsigned idx;
    line_t       line;
    idx  = int'((pc / LINE_BYTES) % MEM_LINES);
    line = mem_copy[idx];
    return pc[2] ? line[63:32] : line[31:0];
endfunction

// --------------------------------------------------
// Checks and reporting
// --------------------------------------------------
task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
        $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, got);
        err_cnt++;
    end
endtask

// Compare the instruction on the output against the reference stream
task automatic check_instr(input addr_t exp_pc);
    instr_t exp_instr;
    exp_instr = ref_instr(exp_pc);
    check_value("instr_pc_o", instr_pc_o, exp_pc);
    check_value("instr_o", 64'(instr_o), 64'(exp_instr));
endtask

task automatic report_row(input int unsigned idx, input int unsigned n_checked,
                          input int unsigned n_err);
    if (n_err == 0) begin
        rows_passed++;
        $display("Row %0d: PASS, %0d instructions checked", idx, n_checked);
    end else begin
        rows_failed++;
        $display("Row %0d: FAIL, %0d errors over %0d instructions", idx, n_err, n_checked);
    end
endtask

`endif

// File: test/tb_fetch_subsys.sv
// Fetch subsystem testbench that checks a table of fetch scenarios against a reference stream
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_subsys
    import fetch_types_pkg::*;
    import fetch_ctrl_pkg::*;
();

    localparam int unsigned BUF_DEPTH    = 4;
    localparam int unsigned MEM_LINES    = 64;
    localparam int unsigned IDX_W        = $clog2(MEM_LINES);
    localparam int unsigned N_ROWS       = 7;
    localparam int unsigned RESET_CYCLES = 4;
    localparam int unsigned IDLE_CYCLES  = 3;
    localparam int unsigned DRIVE_DELAY  = 1;
    localparam logic [31:0] SEED         = 32'hbdcb8993;

    // One scenario with start, optional redirect, stall rate and stream length
    typedef struct packed {
        addr_t      start_addr;
        logic       redir_en;
        logic [7:0] redir_after;
        addr_t      redir_addr;
        logic [7:0] stall_pct;
        logic [7:0] n_instr;
    } test_row_t;

    logic             clk_i;
    logic             rst_ni;
    logic             fetch_enable_i;
    addr_t            boot_addr_i;
    logic             redirect_i;
    addr_t            redirect_addr_i;
    logic             stall_i;
    logic             mem_we_i;
    logic [IDX_W-1:0] mem_waddr_i;
    line_t            mem_wdata_i;
    logic             instr_valid_o;
    instr_t           instr_o;
    addr_t            instr_pc_o;
    logic             fetch_busy_o;

    line_t       mem_copy [MEM_LINES];
    test_row_t   rows [N_ROWS];
    int unsigned err_cnt     = 0;
    int unsigned rows_passed = 0;
    int unsigned rows_failed = 0;
    int unsigned cycle_cnt   = 0;
    int unsigned cycle_limit = 0;

    `include "tb_fetch_tasks.svh"

    fetch_subsys #(
        .BUF_DEPTH ( BUF_DEPTH ),
        .MEM_LINES ( MEM_LINES )
    ) i_fetch_subsys (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .fetch_enable_i  ( fetch_enable_i  ),
        .boot_addr_i     ( boot_addr_i     ),
        .redirect_i      ( redirect_i      ),
        .redirect_addr_i ( redirect_addr_i ),
        .stall_i         ( stall_i         ),
        .mem_we_i        ( mem_we_i        ),
        .mem_waddr_i     ( mem_waddr_i     ),
        .mem_wdata_i     ( mem_wdata_i     ),
        .instr_valid_o   ( instr_valid_o   ),
        .instr_o         ( instr_o         ),
        .instr_pc_o      ( instr_pc_o      ),
        .fetch_busy_o    ( fetch_busy_o    )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    function automatic test_row_t make_row(input addr_t start, input logic redir_en,
                                           input int unsigned redir_after, input addr_t redir_addr,
                                           input int unsigned stall_pct, input int unsigned n_instr);
        test_row_t r;
        r.start_addr  = start;
        r.redir_en    = redir_en;
        r.redir_after = 8'(redir_after);
        r.redir_addr  = redir_addr;
        r.stall_pct   = 8'(stall_pct);
        r.n_instr     = 8'(n_instr);
        return r;
    endfunction

    task automatic fill_table();
        // Aligned boot and boot into the upper half
        rows[0] = make_row(64'h8000_0000, 1'b0, 0, '0, 0, 16);
        rows[1] = make_row(64'h8000_0104, 1'b0, 0, '0, 0, 9);
        // Random stalls where the heavy rate fills the buffer
        rows[2] = make_row(64'h8000_0040, 1'b0, 0, '0, 40, 24);
        rows[3] = make_row(64'h8000_0080, 1'b0, 0, '0, 75, 20);
        // Redirect in mid stream
        rows[4] = make_row(64'h8000_0000, 1'b1, 5, 64'h8000_0124, 20, 12);
        // Runs past the last line
        rows[5] = make_row(64'h0000_01e8, 1'b0, 0, '0, 30, 14);
        rows[6] = make_row(64'h0000_0100, 1'b1, 3, 64'h0000_01f8, 0, 8);
    endtask

    task automatic apply_reset(input addr_t boot);
        @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni         = 1'b0;
        fetch_enable_i = 1'b0;
        redirect_i     = 1'b0;
        stall_i        = 1'b0;
        boot_addr_i    = boot;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
    endtask

    // --------------------------------------------------
    // One row with its scoreboard
    // --------------------------------------------------
    task automatic run_row(input int unsigned idx);
        test_row_t   r;
        addr_t       exp_pc;
        int unsigned got;
        int unsigned checked;
        int unsigned errs_before;
        logic        redirected;
        logic        done;
        r           = rows[idx];
        errs_before = err_cnt;
        apply_reset(r.start_addr);
        // Quiet until enable rises
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            check_value("instr_valid_o", 64'(instr_valid_o), 64'd0);
            check_value("fetch_busy_o", 64'(fetch_busy_o), 64'd0);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        fetch_enable_i = 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        check_value("fetch_busy_o", 64'(fetch_busy_o), 64'd1);

        exp_pc     = r.start_addr;
        got        = 0;
        checked    = 0;
        redirected = !r.redir_en;
        done       = 1'b0;
        while (!done) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            stall_i    = (($urandom % 100) < r.stall_pct);
            redirect_i = 1'b0;
            if (!redirected && got == r.redir_after) begin
                // New path starts here and no old instruction may follow
                redirect_i      = 1'b1;
                redirect_addr_i = r.redir_addr;
                exp_pc          = r.redir_addr;
                got             = 0;
                redirected      = 1'b1;
            end
            @(negedge clk_i);
            if (instr_valid_o) begin
                check_instr(exp_pc);
                exp_pc = exp_pc + 64'd4;
                got++;
                checked++;
            end
            done = redirected && (got == r.n_instr);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        stall_i        = 1'b0;
        redirect_i     = 1'b0;
        fetch_enable_i = 1'b0;
        report_row(idx, checked, err_cnt - errs_before);
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin : watchdog
        fetch_state_e st;
        wait (cycle_limit != 0);
        while (cycle_cnt <= cycle_limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        st = i_fetch_subsys.i_fetch_unit.state_q;
        $display("Timeout after %0d cycles, fetch FSM in state %s", cycle_cnt, st.name());
        $display("test failed");
        $finish;
    end

    initial begin : main
        int unsigned total;
        fetch_enable_i  = 1'b0;
        boot_addr_i     = '0;
        redirect_i      = 1'b0;
        redirect_addr_i = '0;
        stall_i         = 1'b0;
        mem_we_i        = 1'b0;
        mem_waddr_i     = '0;
        mem_wdata_i     = '0;
        rst_ni          = 1'b0;
        void'($urandom(SEED));
        fill_table();
        // Limit from the number of expected instructions
        total = 0;
        for (int unsigned i = 0; i < N_ROWS; i++) begin
            total += rows[i].n_instr + (rows[i].redir_en ? rows[i].redir_after : 0);
        end
        cycle_limit = 20 * total + 100;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        preload_mem();
        for (int unsigned i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end
        $display("Summary: %0d rows passed, %0d rows failed, %0d errors",
                 rows_passed, rows_failed, err_cnt);
        if (rows_failed == 0 && err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_subsys.f
+incdir+include
hw/fetch_types_pkg.sv
hw/fetch_ctrl_pkg.sv
hw/fetch_unit.sv
hw/instr_mem.sv
hw/line_buffer.sv
hw/instr_realign.sv
hw/fetch_subsys.sv
test/tb_fetch_subsys.sv
